/* common/banked_rf_cfg.svh */
//##########################################################################
// Sizes for the banked register file. RF_NUM_REGS must be a power of two
// and at least 4, since registers are split over two banks by address bit 0
//##########################################################################
`ifndef BANKED_RF_CFG_SVH
`define BANKED_RF_CFG_SVH

// Width of one register word
`define RF_DATA_WIDTH 32

// Total register count over both banks
`define RF_NUM_REGS 32

// Width of the caller's read tag
`define RF_USER_TAG_W 4

// Contents of every register after reset
`define RF_RESET_VALUE {`RF_DATA_WIDTH{1'b1}}

`endif

/* common/banked_rf_pkg.sv */
//##########################################################################
// Types shared by the router, banks and merger
//##########################################################################
`default_nettype none

`include "banked_rf_cfg.svh"

package banked_rf_pkg;

    // Full register address width
    localparam int unsigned RF_ADDR_W = $clog2(`RF_NUM_REGS);

    // Full address, bit 0 selects the bank
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // Address inside one bank, full address without bit 0
    typedef logic [RF_ADDR_W-2:0] bank_addr_t;

    // One register word
    typedef logic [`RF_DATA_WIDTH-1:0] rf_data_t;

    // Tag supplied by the caller with each read
    typedef logic [`RF_USER_TAG_W-1:0] user_tag_t;

    // Tag carried through a bank, port says which read port asked
    typedef struct packed {
        user_tag_t user_tag;
        logic      port;
    } bank_tag_t;

    // Operation handed to a bank in one cycle
    typedef enum logic [1:0] {
        BANK_IDLE  = 2'd0,
        BANK_WRITE = 2'd1,
        BANK_READ  = 2'd2
    } bank_op_e;

endpackage

`default_nettype wire

/* common/rf_bank_if.sv */
//##########################################################################
// Request and response of one bank. The response follows a BANK_READ
// request by exactly one cycle
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

interface rf_bank_if
    import banked_rf_pkg::*;
();

    // Request side, driven by the router
    bank_op_e   op;
    bank_addr_t addr;
    rf_data_t   wdata;
    bank_tag_t  req_tag;

    // Response side, driven by the bank
    logic       rsp_valid;
    bank_tag_t  rsp_tag;
    rf_data_t   rsp_data;

    // Router drives one request per cycle
    modport router (
        output op, addr, wdata, req_tag
    );

    // Bank executes the request
    modport bank (
        input  op, addr, wdata, req_tag,
        output rsp_valid, rsp_tag, rsp_data
    );

    // Merger only looks at responses
    modport merge (
        input rsp_valid, rsp_tag, rsp_data
    );

endinterface

`default_nettype wire

/* rtl/rf_bank/rf_bank.sv */
//##########################################################################
// Single-port bank holding half of the registers in flops. No arbitration
// here, the op given each cycle is executed as is
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

`include "banked_rf_cfg.svh"

module rf_bank
    import banked_rf_pkg::*;
(
    // Clock and reset
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // Request in, response out
    rf_bank_if.bank   bank_i
);

    // Registers held by this bank
    localparam int unsigned BANK_REGS = `RF_NUM_REGS / 2;

    //######################################################################
    // Signals
    //######################################################################

    // Register array
    rf_data_t  regs_q [BANK_REGS];

    // Response pipeline stage
    logic      rsp_valid_q;
    bank_tag_t rsp_tag_q;
    rf_data_t  rsp_data_q;

    // Decoded op
    logic      do_write;
    logic      do_read;

    assign do_write = (bank_i.op == BANK_WRITE);
    assign do_read  = (bank_i.op == BANK_READ);

    //######################################################################
    // Register array
    //######################################################################

    // All registers come out of reset as all ones
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BANK_REGS; i++) begin
                regs_q[i] <= `RF_RESET_VALUE;
            end
        end else if (do_write) begin
            regs_q[bank_i.addr] <= bank_i.wdata;
        end
    end

    //######################################################################
    // Registered read
    //######################################################################

    // Valid marks the cycle after an accepted read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= do_read;
        end
    end

    // Data and tag only matter while valid is high
    always_ff @(posedge clk_i) begin
        if (do_read) begin
            rsp_data_q <= regs_q[bank_i.addr];
            rsp_tag_q  <= bank_i.req_tag;
        end
    end

    // Response straight from the pipeline flops
    assign bank_i.rsp_valid = rsp_valid_q;
    assign bank_i.rsp_tag   = rsp_tag_q;
    assign bank_i.rsp_data  = rsp_data_q;

endmodule

`default_nettype wire

/* rtl/bank_router.sv */
//##########################################################################
// Combinational arbiter, write beats reads, read 0 beats read 1. Ready
// depends only on valids and addresses, the write is always ready
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module bank_router
    import banked_rf_pkg::*;
(
    // Write request
    input  wire logic      wr_valid_i,
    input  wire rf_addr_t  wr_addr_i,
    input  wire rf_data_t  wr_data_i,
    output logic           wr_ready_o,

    // Read request 0
    input  wire logic      rd0_valid_i,
    input  wire rf_addr_t  rd0_addr_i,
    input  wire user_tag_t rd0_tag_i,
    output logic           rd0_ready_o,

    // Read request 1
    input  wire logic      rd1_valid_i,
    input  wire rf_addr_t  rd1_addr_i,
    input  wire user_tag_t rd1_tag_i,
    output logic           rd1_ready_o,

    // One request per bank
    rf_bank_if.router      bank0_o,
    rf_bank_if.router      bank1_o
);

    // Per-bank winners
    logic [1:0] wr_take;
    logic [1:0] rd0_take;
    logic [1:0] rd1_take;

    // Per-bank request fields
    bank_op_e   bank_op   [2];
    bank_addr_t bank_addr [2];
    bank_tag_t  bank_tag  [2];

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            // Priority chain for bank b
            wr_take[b]  = wr_valid_i && (wr_addr_i[0] == b[0]);
            rd0_take[b] = rd0_valid_i && (rd0_addr_i[0] == b[0]) && !wr_take[b];
            rd1_take[b] = rd1_valid_i && (rd1_addr_i[0] == b[0])
                          && !wr_take[b] && !rd0_take[b];

            // Default idle
            bank_op[b]   = BANK_IDLE;
            bank_addr[b] = '0;
            bank_tag[b]  = '0;

            if (wr_take[b]) begin
                bank_op[b]   = BANK_WRITE;
                bank_addr[b] = wr_addr_i[RF_ADDR_W-1:1];
            end else if (rd0_take[b]) begin
                bank_op[b]   = BANK_READ;
                bank_addr[b] = rd0_addr_i[RF_ADDR_W-1:1];
                bank_tag[b]  = '{user_tag: rd0_tag_i, port: 1'b0};
            end else if (rd1_take[b]) begin
                bank_op[b]   = BANK_READ;
                bank_addr[b] = rd1_addr_i[RF_ADDR_W-1:1];
                bank_tag[b]  = '{user_tag: rd1_tag_i, port: 1'b1};
            end
        end
    end

    // Write never loses
    assign wr_ready_o  = 1'b1;
    // Blocked by a write to the same bank
    assign rd0_ready_o = !(wr_valid_i && (wr_addr_i[0] == rd0_addr_i[0]));
    // Blocked by a write or by read 0 on the same bank
    assign rd1_ready_o = !(wr_valid_i && (wr_addr_i[0] == rd1_addr_i[0]))
                         && !(rd0_valid_i && (rd0_addr_i[0] == rd1_addr_i[0]));

    // Bank 0, even addresses
    assign bank0_o.op      = bank_op[0];
    assign bank0_o.addr    = bank_addr[0];
    assign bank0_o.wdata   = wr_data_i;
    assign bank0_o.req_tag = bank_tag[0];

    // Bank 1, odd addresses
    assign bank1_o.op      = bank_op[1];
    assign bank1_o.addr    = bank_addr[1];
    assign bank1_o.wdata   = wr_data_i;
    assign bank1_o.req_tag = bank_tag[1];

endmodule

`default_nettype wire

/* rtl/read_merge.sv */
//##########################################################################
// Routes bank responses to result ports by the port bit of their tag.
// Relies on the router never sending one port's read to both banks
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module read_merge
    import banked_rf_pkg::*;
(
    // Bank responses
    rf_bank_if.merge bank0_i,
    rf_bank_if.merge bank1_i,

    // Result port 0
    output logic      res0_valid_o,
    output user_tag_t res0_tag_o,
    output rf_data_t  res0_data_o,

    // Result port 1
    output logic      res1_valid_o,
    output user_tag_t res1_tag_o,
    output rf_data_t  res1_data_o
);

    // Bank to port matches
    logic b0_to_res0;
    logic b1_to_res0;
    logic b0_to_res1;
    logic b1_to_res1;

    assign b0_to_res0 = bank0_i.rsp_valid && (bank0_i.rsp_tag.port == 1'b0);
    assign b1_to_res0 = bank1_i.rsp_valid && (bank1_i.rsp_tag.port == 1'b0);
    assign b0_to_res1 = bank0_i.rsp_valid && (bank0_i.rsp_tag.port == 1'b1);
    assign b1_to_res1 = bank1_i.rsp_valid && (bank1_i.rsp_tag.port == 1'b1);

    // Port 0, bank 1 if it matches else bank 0
    assign res0_valid_o = b0_to_res0 || b1_to_res0;
    assign res0_tag_o   = b1_to_res0 ? bank1_i.rsp_tag.user_tag
                                     : bank0_i.rsp_tag.user_tag;
    assign res0_data_o  = b1_to_res0 ? bank1_i.rsp_data : bank0_i.rsp_data;

    // Port 1, same selection
    assign res1_valid_o = b0_to_res1 || b1_to_res1;
    assign res1_tag_o   = b1_to_res1 ? bank1_i.rsp_tag.user_tag
                                     : bank0_i.rsp_tag.user_tag;
    assign res1_data_o  = b1_to_res1 ? bank1_i.rsp_data : bank0_i.rsp_data;

endmodule

`default_nettype wire

/* rtl/banked_regfile.sv */
//##########################################################################
// Two-bank register file, one write and two read ports. Reads return one
// cycle after acceptance, results cannot be stalled
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module banked_regfile
    import banked_rf_pkg::*;
(
    // Clock and reset
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,

    // Write port
    input  wire logic      wr_valid_i,
    input  wire rf_addr_t  wr_addr_i,
    input  wire rf_data_t  wr_data_i,
    output logic           wr_ready_o,

    // Read port 0
    input  wire logic      rd0_valid_i,
    input  wire rf_addr_t  rd0_addr_i,
    input  wire user_tag_t rd0_tag_i,
    output logic           rd0_ready_o,

    // Read port 1
    input  wire logic      rd1_valid_i,
    input  wire rf_addr_t  rd1_addr_i,
    input  wire user_tag_t rd1_tag_i,
    output logic           rd1_ready_o,

    // Result port 0
    output logic           res0_valid_o,
    output user_tag_t      res0_tag_o,
    output rf_data_t       res0_data_o,

    // Result port 1
    output logic           res1_valid_o,
    output user_tag_t      res1_tag_o,
    output rf_data_t       res1_data_o
);

    // One link per bank, index is address bit 0
    rf_bank_if bank_if [2] ();

    // Request arbitration
    bank_router u_router (
        .wr_valid_i  (wr_valid_i),
        .wr_addr_i   (wr_addr_i),
        .wr_data_i   (wr_data_i),
        .wr_ready_o  (wr_ready_o),
        .rd0_valid_i (rd0_valid_i),
        .rd0_addr_i  (rd0_addr_i),
        .rd0_tag_i   (rd0_tag_i),
        .rd0_ready_o (rd0_ready_o),
        .rd1_valid_i (rd1_valid_i),
        .rd1_addr_i  (rd1_addr_i),
        .rd1_tag_i   (rd1_tag_i),
        .rd1_ready_o (rd1_ready_o),
        .bank0_o     (bank_if[0]),
        .bank1_o     (bank_if[1])
    );

    // Even registers
    rf_bank u_bank0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bank_i  (bank_if[0])
    );

    // Odd registers
    rf_bank u_bank1 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bank_i  (bank_if[1])
    );

    // Response steering
    read_merge u_merge (
        .bank0_i      (bank_if[0]),
        .bank1_i      (bank_if[1]),
        .res0_valid_o (res0_valid_o),
        .res0_tag_o   (res0_tag_o),
        .res0_data_o  (res0_data_o),
        .res1_valid_o (res1_valid_o),
        .res1_tag_o   (res1_tag_o),
        .res1_data_o  (res1_data_o)
    );

endmodule

`default_nettype wire

/* testbench/banked_rf_props.sv */
//##########################################################################
// Bound handshake and conflict properties, checked only out of reset
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

module banked_rf_props
    import banked_rf_pkg::*;
(
    input wire logic     clk_i,
    input wire logic     rst_n_i,
    input wire logic     wr_valid_i,
    input wire rf_addr_t wr_addr_i,
    input wire logic     wr_ready_o,
    input wire logic     rd0_valid_i,
    input wire rf_addr_t rd0_addr_i,
    input wire logic     rd0_ready_o,
    input wire logic     rd1_valid_i,
    input wire rf_addr_t rd1_addr_i,
    input wire logic     rd1_ready_o,
    input wire logic     res0_valid_o,
    input wire logic     res1_valid_o
);

    // Write always wins its bank
    a_wr_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i) wr_ready_o)
        else $error("Write ready went low");

    // Held in reset for a second cycle, so the flops are settled
    a_res_reset: assert property (@(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |-> (!res0_valid_o && !res1_valid_o))
        else $error("Result valid high during reset");

    // One-cycle read latency on each path
    a_res0_lat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res0_valid_o == $past(rd0_valid_i && rd0_ready_o))
        else $error("Result 0 not exactly one cycle after its read");
    a_res1_lat: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res1_valid_o == $past(rd1_valid_i && rd1_ready_o))
        else $error("Result 1 not exactly one cycle after its read");

    // Read 0 beats read 1 on a shared bank
    a_rd1_loses: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rd0_valid_i && rd1_valid_i && (rd0_addr_i[0] == rd1_addr_i[0])
         && !(wr_valid_i && (wr_addr_i[0] == rd1_addr_i[0]))) |-> !rd1_ready_o)
        else $error("Read 1 ready high against read 0 on the same bank");

endmodule

bind banked_regfile banked_rf_props u_props (.*);

`default_nettype wire

/* testbench/banked_rf_tb.sv */
//##########################################################################
// Random and directed traffic on all three request ports, checked against
// a register model. Requests are held until accepted, as the bus requires
//##########################################################################
`timescale 1ns/100ps
`default_nettype none

`include "banked_rf_cfg.svh"

module banked_rf_tb
    import banked_rf_pkg::*;
();

    // Cycles a request may wait for ready
    localparam int unsigned HOLD_LIMIT = 32;
    localparam int unsigned MIX_CYCLES = 600;

    logic      clk_i;
    logic      rst_n_i;
    logic      wr_valid_i;
    rf_addr_t  wr_addr_i;
    rf_data_t  wr_data_i;
    logic      wr_ready_o;
    logic      rd0_valid_i;
    rf_addr_t  rd0_addr_i;
    user_tag_t rd0_tag_i;
    logic      rd0_ready_o;
    logic      rd1_valid_i;
    rf_addr_t  rd1_addr_i;
    user_tag_t rd1_tag_i;
    logic      rd1_ready_o;
    logic      res0_valid_o;
    user_tag_t res0_tag_o;
    rf_data_t  res0_data_o;
    logic      res1_valid_o;
    user_tag_t res1_tag_o;
    rf_data_t  res1_data_o;

    // Held requests, index 0 write, 1 and 2 the read ports
    logic        req_v   [3];
    rf_addr_t    req_a   [3];
    user_tag_t   req_t   [3];
    int unsigned req_age [3];
    rf_data_t    req_wd;
    logic        acc     [3];

    // Expected result per result port for the next cycle
    logic        exp_v   [2];
    user_tag_t   exp_t   [2];
    rf_data_t    exp_d   [2];

    // Register model
    rf_data_t    model_regs [`RF_NUM_REGS];

    logic [31:0] rng;
    string       cur_test;
    int unsigned errors;
    int unsigned checks;
    int unsigned tests;
    int unsigned err_at_start;
    logic        timed_out;

    banked_regfile dut_i (.*);

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            $display("ERROR %s %s expected %0h actual %0h", cur_test, what, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic set_write(input rf_addr_t a, input rf_data_t d);
        req_v[0]   = 1'b1;
        req_a[0]   = a;
        req_wd     = d;
        req_age[0] = 0;
    endtask

    task automatic set_read(input int p, input rf_addr_t a, input user_tag_t t);
        req_v[p+1]   = 1'b1;
        req_a[p+1]   = a;
        req_t[p+1]   = t;
        req_age[p+1] = 0;
    endtask

    //######################################################################
    // One bus cycle, drive at the rising edge and check at the falling one
    //######################################################################
    task automatic run_cycle();
        logic [2:0] rdy;
        logic [1:0] busy;
        @(posedge clk_i);
        wr_valid_i  <= req_v[0];
        wr_addr_i   <= req_a[0];
        wr_data_i   <= req_wd;
        rd0_valid_i <= req_v[1];
        rd0_addr_i  <= req_a[1];
        rd0_tag_i   <= req_t[1];
        rd1_valid_i <= req_v[2];
        rd1_addr_i  <= req_a[2];
        rd1_tag_i   <= req_t[2];
        @(negedge clk_i);
        // Responses to reads accepted at this rising edge
        check_val("res0_valid", exp_v[0], res0_valid_o);
        if (exp_v[0]) begin
            check_val("res0_tag", exp_t[0], res0_tag_o);
            check_val("res0_data", exp_d[0], res0_data_o);
        end
        check_val("res1_valid", exp_v[1], res1_valid_o);
        if (exp_v[1]) begin
            check_val("res1_tag", exp_t[1], res1_tag_o);
            check_val("res1_data", exp_d[1], res1_data_o);
        end
        // Banks claimed in priority order write, read 0, read 1
        busy   = 2'b00;
        rdy[0] = 1'b1;
        if (req_v[0]) begin
            busy[req_a[0][0]] = 1'b1;
        end
        rdy[1] = !busy[req_a[1][0]];
        if (req_v[1] && rdy[1]) begin
            busy[req_a[1][0]] = 1'b1;
        end
        rdy[2] = !busy[req_a[2][0]];
        check_val("wr_ready", rdy[0], wr_ready_o);
        check_val("rd0_ready", rdy[1], rd0_ready_o);
        check_val("rd1_ready", rdy[2], rd1_ready_o);
        for (int p = 0; p < 3; p++) begin
            acc[p] = req_v[p] && rdy[p];
        end
        // Reads see the model before this cycle's write
        exp_v[0] = acc[1];
        exp_t[0] = req_t[1];
        exp_d[0] = model_regs[req_a[1]];
        exp_v[1] = acc[2];
        exp_t[1] = req_t[2];
        exp_d[1] = model_regs[req_a[2]];
        if (acc[0]) begin
            model_regs[req_a[0]] = req_wd;
        end
        for (int p = 0; p < 3; p++) begin
            if (acc[p]) begin
                req_v[p] = 1'b0;
            end else if (req_v[p]) begin
                req_age[p]++;
                if (req_age[p] > HOLD_LIMIT && !timed_out) begin
                    $display("Request on port %0d starved for %0d cycles", p, HOLD_LIMIT);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    // Run until every held request is accepted
    task automatic wait_accepted();
        int n;
        for (n = 0; n < HOLD_LIMIT && (req_v[0] || req_v[1] || req_v[2]) && !timed_out; n++)
            run_cycle();
        if ((req_v[0] || req_v[1] || req_v[2]) && !timed_out) begin
            $display("Handshake wait in %s timed out after %0d cycles", cur_test, n);
            timed_out = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        // Last responses land one cycle later
        run_cycle();
        tests++;
        $display("Test %s done, %0d errors", cur_test, errors - err_at_start);
    endtask

    //######################################################################
    // Tests
    //######################################################################
    task automatic test_reset_contents();
        begin_test("reset_contents");
        for (int i = 0; i < `RF_NUM_REGS; i += 2) begin
            set_read(0, rf_addr_t'(i), user_tag_t'(i));
            set_read(1, rf_addr_t'(i + 1), ~user_tag_t'(i));
            wait_accepted();
        end
        end_test();
    endtask

    task automatic test_write_read();
        rf_addr_t a;
        begin_test("write_read");
        for (int k = 0; k < 24; k++) begin
            a = rf_addr_t'(next_rand());
            set_write(a, next_rand());
            wait_accepted();
            // Read right behind its write
            set_read(k % 2, a, user_tag_t'(k));
            wait_accepted();
        end
        end_test();
    endtask

    task automatic test_conflicts();
        rf_addr_t a;
        begin_test("conflicts");
        for (int k = 0; k < 8; k++) begin
            a = rf_addr_t'(next_rand());
            set_write(a, next_rand());
            set_read(0, a, user_tag_t'(k));
            run_cycle();
            check_val("wr_vs_rd0 write taken", 1'b1, wr_valid_i && wr_ready_o);
            check_val("wr_vs_rd0 read held", 1'b0, rd0_valid_i && rd0_ready_o);
            wait_accepted();
            // Flip bit 1, same bank
            set_read(0, a, user_tag_t'(k));
            set_read(1, a ^ rf_addr_t'(2), ~user_tag_t'(k));
            run_cycle();
            check_val("rd0_vs_rd1 rd0 taken", 1'b1, rd0_valid_i && rd0_ready_o);
            check_val("rd0_vs_rd1 rd1 held", 1'b0, rd1_valid_i && rd1_ready_o);
            wait_accepted();
            // Write and read on opposite banks
            set_write(a, next_rand());
            set_read(1, a ^ rf_addr_t'(1), user_tag_t'(k));
            run_cycle();
            check_val("split banks both taken", 1'b1,
                      wr_valid_i && wr_ready_o && rd1_valid_i && rd1_ready_o);
            wait_accepted();
        end
        end_test();
    endtask

    task automatic test_steering();
        rf_addr_t a0;
        rf_addr_t a1;
        begin_test("steering");
        for (int k = 0; k < 12; k++) begin
            a0 = rf_addr_t'(next_rand());
            a1 = rf_addr_t'(next_rand());
            a1[0] = ~a0[0];
            set_read(0, a0, user_tag_t'(next_rand()));
            set_read(1, a1, user_tag_t'(next_rand()));
            run_cycle();
            check_val("both reads taken", 1'b1,
                      rd0_valid_i && rd0_ready_o && rd1_valid_i && rd1_ready_o);
            wait_accepted();
        end
        end_test();
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        begin_test("random_mix");
        for (int c = 0; c < MIX_CYCLES && !timed_out; c++) begin
            r = next_rand();
            if (!req_v[0] && r[0]) set_write(rf_addr_t'(r >> 3), next_rand());
            if (!req_v[1] && r[1]) set_read(0, rf_addr_t'(r >> 11), user_tag_t'(r >> 19));
            if (!req_v[2] && r[2]) set_read(1, rf_addr_t'(r >> 23), user_tag_t'(r >> 28));
            run_cycle();
        end
        wait_accepted();
        end_test();
    endtask

    initial begin
        rng       = 32'h8b69_dbc5;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        rst_n_i     = 1'b0;
        wr_valid_i  = 1'b0;
        wr_addr_i   = '0;
        wr_data_i   = '0;
        rd0_valid_i = 1'b0;
        rd0_addr_i  = '0;
        rd0_tag_i   = '0;
        rd1_valid_i = 1'b0;
        rd1_addr_i  = '0;
        rd1_tag_i   = '0;
        req_wd      = '0;
        for (int p = 0; p < 3; p++) begin
            req_v[p]   = 1'b0;
            req_a[p]   = '0;
            req_t[p]   = '0;
            req_age[p] = 0;
        end
        exp_v[0] = 1'b0;
        exp_v[1] = 1'b0;
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            model_regs[i] = `RF_RESET_VALUE;
        end
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        test_reset_contents();
        test_write_read();
        test_conflicts();
        test_steering();
        test_random_mix();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* banked_rf.f */
+incdir+common
common/banked_rf_pkg.sv
common/rf_bank_if.sv
rtl/rf_bank/rf_bank.sv
rtl/bank_router.sv
rtl/read_merge.sv
rtl/banked_regfile.sv
testbench/banked_rf_props.sv
testbench/banked_rf_tb.sv
